// ==== compile.f ====
+incdir+src
src/x86_decode_pkg.sv
src/prefix_strip.sv
src/opcode_form_lookup.sv
src/decode_opnd_signals.sv
src/instr_length_calc.sv
src/x86_decode_top.sv
dv/x86_decode_tb.sv

// ==== dv/x86_decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_params.svh"

module x86_decode_tb;

  import x86_decode_pkg::*;

  // Rising edges from the drive edge to the edge that raises out_valid
  localparam int LATENCY    = 2;
  localparam int MAX_CASES  = 32;
  // Extra cycles allowed beyond the expected arrival of the last result
  localparam int WAIT_LIMIT = 20;

  // One table row, instruction bytes listed in reading order
  // Flags bit order is has_modrm has_sib has_disp is_disp8 is_disp32 reg_direct has_imm
  typedef struct packed {
    logic [63:0] code;
    logic [3:0]  used;
    opnd_form_t  form;
    instr_len_t  len;
    disp_t       disp;
    imm_t        imm;
    opnd_roles_t roles;
    logic        invalid;
    logic [6:0]  flags;
    byte_t       modrm;
    byte_t       sib;
  } case_row_t;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           in_valid;
  window_t        in_bytes;
  logic           out_valid;
  decode_result_t out_result;

  case_row_t rows [MAX_CASES];
  string     names [MAX_CASES];
  int        num_cases;
  integer    seed;

  x86_decode_top x86_decode_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_bytes   (in_bytes),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_form(input string name, input opnd_form_t exp, input opnd_form_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: opnd_form expected %s actual %s",
                               name, exp.name(), act.name()));
    end
  endtask

  task automatic check_len(input string name, input instr_len_t exp, input instr_len_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: length expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_disp(input string name, input disp_t exp, input disp_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: disp expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_imm(input string name, input imm_t exp, input imm_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: imm expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_roles(input string name, input opnd_roles_t exp, input opnd_roles_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: roles expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input string field, input logic exp,
                            input logic act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: %s expected %b actual %b", name, field, exp, act));
    end
  endtask

  task automatic check_byte(input string name, input string field, input byte_t exp,
                            input byte_t act);
    if (exp !== act) begin
      report_failure($sformatf("Fail %s: %s expected %h actual %h", name, field, exp, act));
    end
  endtask

  task automatic add_case(input string name, input logic [63:0] code, input int used,
                          input opnd_form_t form, input instr_len_t len, input disp_t disp,
                          input imm_t imm, input opnd_roles_t roles, input logic invalid,
                          input logic [6:0] flags, input byte_t modrm, input byte_t sib);
    case_row_t r;
    r.code             = code;
    r.used             = used[3:0];
    r.form             = form;
    r.len              = len;
    r.disp             = disp;
    r.imm              = imm;
    r.roles            = roles;
    r.invalid          = invalid;
    r.flags            = flags;
    r.modrm            = modrm;
    r.sib              = sib;
    names[num_cases]   = name;
    rows[num_cases]    = r;
    num_cases          = num_cases + 1;
  endtask

  // Roles bit order is rm0 reg0 disp0 rm1 reg1 disp1
  task automatic fill_table();
    num_cases = 0;
    // ModR/M forms
    add_case("add_reg_direct", 64'h01D8, 2, OPND_ENC_MODREGRM_RM_REG, 4'd2,
             32'h0000_0000, 32'h0000_0000, 6'b100_010, 1'b0, 7'b1000010, 8'hD8, 8'h00);
    add_case("mov_disp8_neg", 64'h8B45F0, 3, OPND_ENC_MODREGRM_REG_RM, 4'd3,
             32'hFFFF_FFF0, 32'h0000_0000, 6'b010_101, 1'b0, 7'b1011000, 8'h45, 8'h00);
    add_case("mov_sib_no_disp", 64'h890424, 3, OPND_ENC_MODREGRM_RM_REG, 4'd3,
             32'h0000_0000, 32'h0000_0000, 6'b100_010, 1'b0, 7'b1100000, 8'h04, 8'h24);
    add_case("mov_disp32_only", 64'h8B05_7856_3412, 6, OPND_ENC_MODREGRM_REG_RM, 4'd6,
             32'h1234_5678, 32'h0000_0000, 6'b010_101, 1'b0, 7'b1010100, 8'h05, 8'h00);
    add_case("mov_sib_disp32", 64'h8B_8424_EFBE_ADDE, 7, OPND_ENC_MODREGRM_REG_RM, 4'd7,
             32'hDEAD_BEEF, 32'h0000_0000, 6'b010_101, 1'b0, 7'b1110100, 8'h84, 8'h24);
    // Immediates
    add_case("add_eax_imm32", 64'h05_4433_2211, 5, OPND_ENC_EAX_IMM, 4'd5,
             32'h0000_0000, 32'h1122_3344, 6'b000_000, 1'b0, 7'b0000001, 8'h00, 8'h00);
    add_case("add_rm_imm8", 64'h83C07F, 3, OPND_ENC_MODREGRM_RM_IMM, 4'd3,
             32'h0000_0000, 32'h0000_007F, 6'b100_000, 1'b0, 7'b1000011, 8'hC0, 8'h00);
    add_case("imul_imm8", 64'h6BC1FE, 3, OPND_ENC_MODREGRM_REG_RM_IMM, 4'd3,
             32'h0000_0000, 32'h0000_00FE, 6'b010_100, 1'b0, 7'b1000011, 8'hC1, 8'h00);
    add_case("add_sib_disp8_imm32", 64'h8144_2408_7856_3412, 8, OPND_ENC_MODREGRM_RM_IMM, 4'd8,
             32'h0000_0008, 32'h1234_5678, 6'b101_000, 1'b0, 7'b1111001, 8'h44, 8'h24);
    // Prefixes
    add_case("opsize_imm16", 64'h6605_3412, 4, OPND_ENC_EAX_IMM, 4'd4,
             32'h0000_0000, 32'h0000_1234, 6'b000_000, 1'b0, 7'b0000001, 8'h00, 8'h00);
    add_case("adsize_no_sib", 64'h678B04, 3, OPND_ENC_MODREGRM_REG_RM, 4'd3,
             32'h0000_0000, 32'h0000_0000, 6'b010_100, 1'b0, 7'b1000000, 8'h04, 8'h00);
    // Five prefixes then NOP, length is prefix count plus one
    add_case("five_prefixes", 64'h6667_6667_6690, 6, OPND_ENC_NONE, 4'd6,
             32'h0000_0000, 32'h0000_0000, 6'b000_000, 1'b1, 7'b0000000, 8'h00, 8'h00);
    // Displacement-only and plain forms
    add_case("jmp_rel8", 64'hEBFE, 2, OPND_ENC_DISP8, 4'd2,
             32'hFFFF_FFFE, 32'h0000_0000, 6'b001_000, 1'b0, 7'b0011000, 8'h00, 8'h00);
    add_case("call_rel32", 64'hE8_0010_0000, 5, OPND_ENC_DISP32, 4'd5,
             32'h0000_1000, 32'h0000_0000, 6'b001_000, 1'b0, 7'b0010100, 8'h00, 8'h00);
    add_case("push_reg", 64'h50, 1, OPND_ENC_REG, 4'd1,
             32'h0000_0000, 32'h0000_0000, 6'b000_000, 1'b0, 7'b0000000, 8'h00, 8'h00);
    add_case("ret", 64'hC3, 1, OPND_ENC_NONE, 4'd1,
             32'h0000_0000, 32'h0000_0000, 6'b000_000, 1'b0, 7'b0000000, 8'h00, 8'h00);
    add_case("mov_reg_imm32", 64'hB8_EFCD_AB89, 5, OPND_ENC_REG_IMM, 4'd5,
             32'h0000_0000, 32'h89AB_CDEF, 6'b000_000, 1'b0, 7'b0000001, 8'h00, 8'h00);
    // Unsupported opcodes
    add_case("escape_0f", 64'h0F05, 2, OPND_ENC_INVALID, 4'd1,
             32'h0000_0000, 32'h0000_0000, 6'b000_000, 1'b1, 7'b0000000, 8'h00, 8'h00);
    add_case("undefined_d6", 64'hD6, 1, OPND_ENC_INVALID, 4'd1,
             32'h0000_0000, 32'h0000_0000, 6'b000_000, 1'b1, 7'b0000000, 8'h00, 8'h00);
  endtask

  // Row bytes go first, byte 0 in bits 7:0, the rest is random filler
  function automatic window_t build_window(input logic [63:0] code, input int used);
    window_t     w;
    logic [31:0] rnd;
    for (int i = 0; i < `X86_WINDOW_BYTES; i++) begin
      if (i < used) begin
        w[8*i +: 8] = code[8*(used-1-i) +: 8];
      end else begin
        rnd         = $random(seed);
        w[8*i +: 8] = rnd[7:0];
      end
    end
    return w;
  endfunction

  // One row per rising edge, strobe dropped after the last
  task automatic drive_rows(input int first, input int count);
    case_row_t r;
    for (int k = 0; k < count; k++) begin
      r = rows[first + k];
      @(posedge clk);
      in_valid <= 1'b1;
      in_bytes <= build_window(r.code, int'(r.used));
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // Sampled on the falling edge, results expected in order
  task automatic collect_rows(input int first, input int count);
    int             got;
    int             n;
    int             idx;
    case_row_t      exp;
    decode_result_t act;
    got = 0;
    n   = 0;
    while (got < count) begin
      @(negedge clk);
      n = n + 1;
      if (out_valid) begin
        idx = first + got;
        exp = rows[idx];
        act = out_result;
        // Falling edge n follows rising edge n-1 of the run
        if (n - 1 - got != LATENCY) begin
          report_failure($sformatf("Fail %s: latency expected %0d actual %0d",
                                   names[idx], LATENCY, n - 1 - got));
        end
        check_form(names[idx], exp.form, act.opnd_form);
        check_flag(names[idx], "invalid", exp.invalid, act.invalid);
        check_len(names[idx], exp.len, act.length);
        check_disp(names[idx], exp.disp, act.disp);
        check_imm(names[idx], exp.imm, act.imm);
        check_roles(names[idx], exp.roles, act.roles);
        check_flag(names[idx], "has_modrm", exp.flags[6], act.has_modrm);
        check_flag(names[idx], "has_sib", exp.flags[5], act.has_sib);
        check_flag(names[idx], "has_disp", exp.flags[4], act.has_disp);
        check_flag(names[idx], "is_disp8", exp.flags[3], act.is_disp8);
        check_flag(names[idx], "is_disp32", exp.flags[2], act.is_disp32);
        check_flag(names[idx], "has_imm", exp.flags[0], act.has_imm);
        // Without a ModR/M byte these fields hold filler
        if (exp.flags[6]) begin
          check_byte(names[idx], "modrm", exp.modrm, act.modrm);
          check_flag(names[idx], "reg_direct", exp.flags[1], act.modrm_rm_is_reg_direct);
        end
        if (exp.flags[5]) begin
          check_byte(names[idx], "sib", exp.sib, act.sib);
        end
        got = got + 1;
      end else if (n > count + LATENCY + WAIT_LIMIT) begin
        report_failure($sformatf("No out_valid for case %s within %0d cycles",
                                 names[first + got], n));
      end
    end
  endtask

  task automatic run_batch(input int first, input int count);
    @(negedge clk);
    fork
      drive_rows(first, count);
      collect_rows(first, count);
    join
  endtask

  initial begin
    seed     = 32'h4601_bf01;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_bytes = '0;
    fill_table();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      report_failure("out_valid is not low after reset");
    end

    // Each row alone
    for (int i = 0; i < num_cases; i++) begin
      run_batch(i, 1);
    end

    // Whole table back to back, fresh filler bytes
    run_batch(0, num_cases);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/decode_opnd_signals.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_opnd_signals (
  input  wire  x86_decode_pkg::opc_window_t unescaped_instr,
  input  wire  x86_decode_pkg::opnd_form_t  opnd_form,
  input  wire                               prefix_address_16bit,
  input  wire                               prefix_operand_16bit,
  output logic                              has_imm,
  output logic                              has_modrm,
  output logic                              has_sib,
  output logic                              has_disp,
  output logic                              is_disp8,
  output logic                              is_disp32,
  output x86_decode_pkg::byte_t             modrm,
  output x86_decode_pkg::byte_t             sib,
  output x86_decode_pkg::disp_t             disp,
  output logic                              modrm_rm_is_reg_direct,
  output x86_decode_pkg::opnd_roles_t       roles
);

  import x86_decode_pkg::*;

  // Role of each ModR/M field per form
  logic        rm_is_opnd0;
  logic        reg_is_opnd0;
  logic        reg_is_opnd1;
  // Branch forms with no ModR/M
  logic        form_disp8;
  logic        form_disp32;
  logic [1:0]  mod_field;
  logic [2:0]  rm_field;
  // mod 00 with rm 101 gives a bare disp32
  logic        rm_disp32_only;
  // Byte index of the first displacement byte
  logic [1:0]  disp_pos;
  opc_window_t disp_window;

  // Forms that end with immediate bytes
  assign has_imm = opnd_form inside {OPND_ENC_IMM, OPND_ENC_REG_IMM, OPND_ENC_EAX_IMM,
                                     OPND_ENC_MODREGRM_RM_IMM,
                                     OPND_ENC_MODREGRM_REG_RM_IMM,
                                     OPND_ENC_MODREGRM_RM_REG_IMM};

  // R/M is the first operand when the direction bit is clear
  assign rm_is_opnd0 = opnd_form inside {OPND_ENC_MODREGRM_RM, OPND_ENC_MODREGRM_RM_IMM,
                                         OPND_ENC_MODREGRM_RM_REG,
                                         OPND_ENC_MODREGRM_RM_REG_IMM,
                                         OPND_ENC_MODREGRM_RM_REG_CL};
  // REG first, R/M second
  assign reg_is_opnd0 = opnd_form inside {OPND_ENC_MODREGRM_REG_RM,
                                          OPND_ENC_MODREGRM_REG_RM_IMM};
  assign reg_is_opnd1 = opnd_form inside {OPND_ENC_MODREGRM_RM_REG,
                                          OPND_ENC_MODREGRM_RM_REG_IMM,
                                          OPND_ENC_MODREGRM_RM_REG_CL};

  assign form_disp8  = opnd_form == OPND_ENC_DISP8;
  assign form_disp32 = opnd_form == OPND_ENC_DISP32;

  assign has_modrm = rm_is_opnd0 || reg_is_opnd0;

  // ModR/M follows the opcode, SIB follows ModR/M
  assign modrm     = unescaped_instr[15:8];
  assign sib       = unescaped_instr[23:16];
  assign mod_field = modrm[7:6];
  assign rm_field  = modrm[2:0];

  assign modrm_rm_is_reg_direct = mod_field == 2'b11;
  assign rm_disp32_only         = mod_field == 2'b00 && rm_field == 3'b101;

  // SIB only exists with 32-bit addressing, a memory operand and rm 100
  assign has_sib = has_modrm && !prefix_address_16bit
                   && !modrm_rm_is_reg_direct && rm_field == 3'b100;

  // Displacement from the ModR/M mode or from a branch form
  assign has_disp = (has_modrm && (rm_disp32_only || mod_field == 2'b01
                                   || mod_field == 2'b10))
                    || form_disp8 || form_disp32;

  assign is_disp8  = has_disp && (form_disp8 || (has_modrm && mod_field == 2'b01));
  assign is_disp32 = has_disp && (form_disp32
                                  || (has_modrm && (rm_disp32_only || mod_field == 2'b10)));

  // Opcode byte, then ModR/M and SIB when present
  assign disp_pos    = 2'd1 + {1'b0, has_modrm} + {1'b0, has_sib};
  assign disp_window = unescaped_instr >> {disp_pos, 3'b000};

  // disp8 sign-extended, zero when absent
  always_comb begin
    if (!has_disp) begin
      disp = '0;
    end else if (is_disp8) begin
      disp = {{24{disp_window[7]}}, disp_window[7:0]};
    end else begin
      disp = disp_window[31:0];
    end
  end

  // Branch forms put the displacement on operand 0
  // Otherwise it goes with whichever operand takes R/M
  assign roles = '{
    opnd0_modrm_rm:  rm_is_opnd0,
    opnd0_modrm_reg: reg_is_opnd0,
    opnd0_disp:      form_disp8 || form_disp32 || (has_disp && rm_is_opnd0),
    opnd1_modrm_rm:  reg_is_opnd0,
    opnd1_modrm_reg: reg_is_opnd1,
    opnd1_disp:      has_disp && reg_is_opnd0
  };

endmodule

`default_nettype wire

// ==== src/instr_length_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_params.svh"

module instr_length_calc (
  input  wire  x86_decode_pkg::opc_window_t opc_window,
  input  wire  [`X86_PREFIX_CNT_W-1:0]      prefix_count,
  input  wire                               prefix_operand_16bit,
  input  wire                               has_modrm,
  input  wire                               has_sib,
  input  wire                               has_disp,
  input  wire                               is_disp8,
  input  wire                               has_imm,
  input  wire                               imm_1byte,
  output x86_decode_pkg::imm_t              imm,
  output x86_decode_pkg::instr_len_t        length,
  output logic                              too_long
);

  import x86_decode_pkg::*;

  // Byte counts of the variable fields
  logic [2:0]           disp_len;
  logic [2:0]           imm_len;
  // Byte index of the immediate, also the length without prefixes or imm
  logic [2:0]           imm_pos;
  opc_window_t          imm_window;
  // One bit wider than the length to catch overflow past 15
  logic [`X86_LEN_W:0]  len_sum;

  assign disp_len = !has_disp ? 3'd0 : (is_disp8 ? 3'd1 : 3'd4);

  // imm8 by opcode, else operand size picks 16 or 32 bits
  always_comb begin
    if (!has_imm) begin
      imm_len = 3'd0;
    end else if (imm_1byte) begin
      imm_len = 3'd1;
    end else if (prefix_operand_16bit) begin
      imm_len = 3'd2;
    end else begin
      imm_len = 3'd4;
    end
  end

  assign imm_pos = 3'd1 + {2'b00, has_modrm} + {2'b00, has_sib} + disp_len;

  // Bytes past the opcode window read as zero
  assign imm_window = opc_window >> {imm_pos, 3'b000};

  always_comb begin
    case (imm_len)
      3'd1:    imm = {24'd0, imm_window[7:0]};
      3'd2:    imm = {16'd0, imm_window[15:0]};
      3'd4:    imm = imm_window[31:0];
      default: imm = '0;
    endcase
  end

  assign len_sum = (`X86_LEN_W+1)'(prefix_count) + (`X86_LEN_W+1)'(imm_pos)
                   + (`X86_LEN_W+1)'(imm_len);

  assign too_long = len_sum > `X86_WINDOW_BYTES;
  assign length   = len_sum[`X86_LEN_W-1:0];

endmodule

`default_nettype wire

// ==== src/opcode_form_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_form_lookup (
  input  wire  x86_decode_pkg::byte_t opcode,
  output x86_decode_pkg::opnd_form_t  opnd_form,
  output logic                        imm_1byte
);

  import x86_decode_pkg::*;

  // Subset of the one-byte opcode map
  always_comb begin
    imm_1byte = 1'b0;
    case (opcode) inside
      // ADD and MOV, r/m is the destination
      8'h00, 8'h01, 8'h88, 8'h89: begin
        opnd_form = OPND_ENC_MODREGRM_RM_REG;
      end
      // ADD and MOV, reg is the destination
      8'h02, 8'h03, 8'h8A, 8'h8B: begin
        opnd_form = OPND_ENC_MODREGRM_REG_RM;
      end
      // ADD AL, imm8
      8'h04: begin
        opnd_form = OPND_ENC_EAX_IMM;
        imm_1byte = 1'b1;
      end
      // ADD eAX, imm16/32
      8'h05: begin
        opnd_form = OPND_ENC_EAX_IMM;
      end
      // INC, DEC, PUSH with register in the opcode
      [8'h40:8'h57]: begin
        opnd_form = OPND_ENC_REG;
      end
      // PUSH imm
      8'h68: begin
        opnd_form = OPND_ENC_IMM;
      end
      8'h6A: begin
        opnd_form = OPND_ENC_IMM;
        imm_1byte = 1'b1;
      end
      // IMUL with three operands
      8'h69: begin
        opnd_form = OPND_ENC_MODREGRM_REG_RM_IMM;
      end
      8'h6B: begin
        opnd_form = OPND_ENC_MODREGRM_REG_RM_IMM;
        imm_1byte = 1'b1;
      end
      // Jcc rel8 and JMP rel8
      [8'h70:8'h7F], 8'hEB: begin
        opnd_form = OPND_ENC_DISP8;
      end
      // Group 1 and MOV r/m with imm8
      8'h80, 8'h83, 8'hC6: begin
        opnd_form = OPND_ENC_MODREGRM_RM_IMM;
        imm_1byte = 1'b1;
      end
      // Group 1 and MOV r/m with full-size imm
      8'h81, 8'hC7: begin
        opnd_form = OPND_ENC_MODREGRM_RM_IMM;
      end
      // MOV reg, imm
      [8'hB8:8'hBF]: begin
        opnd_form = OPND_ENC_REG_IMM;
      end
      // Shift group by CL
      8'hD3: begin
        opnd_form = OPND_ENC_MODREGRM_RM_REG_CL;
      end
      // NOP, RET, INT3
      8'h90, 8'hC3, 8'hCC: begin
        opnd_form = OPND_ENC_NONE;
      end
      // CALL and JMP rel32
      8'hE8, 8'hE9: begin
        opnd_form = OPND_ENC_DISP32;
      end
      // Includes the 0x0F escape and other prefixes
      default: begin
        opnd_form = OPND_ENC_INVALID;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/prefix_strip.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_params.svh"

module prefix_strip (
  input  wire  x86_decode_pkg::window_t     instr_bytes,
  output x86_decode_pkg::opc_window_t       opc_window,
  output logic [`X86_PREFIX_CNT_W-1:0]      prefix_count,
  output logic                              prefix_operand_16bit,
  output logic                              prefix_address_16bit,
  output logic                              too_many_prefixes
);

  import x86_decode_pkg::*;

  // Still inside the leading run of prefix bytes
  logic    in_run;
  // Raw window moved down so the opcode lands in byte 0
  window_t shifted;

  always_comb begin
    in_run               = 1'b1;
    prefix_count         = '0;
    prefix_operand_16bit = 1'b0;
    prefix_address_16bit = 1'b0;
    // One byte past the limit is scanned so that a fifth prefix shows up
    for (int i = 0; i <= `X86_MAX_PREFIXES; i++) begin
      if (in_run && instr_bytes[8*i +: 8] == `X86_PREFIX_OPSIZE) begin
        prefix_count         = prefix_count + 1'b1;
        prefix_operand_16bit = 1'b1;
      end else if (in_run && instr_bytes[8*i +: 8] == `X86_PREFIX_ADSIZE) begin
        prefix_count         = prefix_count + 1'b1;
        prefix_address_16bit = 1'b1;
      end else begin
        // First non-prefix byte ends the run
        in_run = 1'b0;
      end
    end
  end

  assign too_many_prefixes = prefix_count > `X86_MAX_PREFIXES;

  // Byte shift by the run length, upper bytes fill with zero
  assign shifted    = instr_bytes >> {prefix_count, 3'b000};
  assign opc_window = shifted[`X86_OPC_BYTES*8-1:0];

endmodule

`default_nettype wire

// ==== src/x86_decode_params.svh ====
`ifndef X86_DECODE_PARAMS_SVH
`define X86_DECODE_PARAMS_SVH

// Raw instruction window offered each strobe, also the architectural length limit
`define X86_WINDOW_BYTES 15

// Opcode-aligned window seen by the operand and length logic
`define X86_OPC_BYTES 9

// Legacy prefixes accepted before the opcode
`define X86_MAX_PREFIXES 4

// Prefix byte values
`define X86_PREFIX_OPSIZE 8'h66
`define X86_PREFIX_ADSIZE 8'h67

// Field widths
`define X86_BYTE_W 8
`define X86_DISP_W 32
`define X86_IMM_W 32
`define X86_LEN_W 4
// Count of 0 to 5 prefix bytes
`define X86_PREFIX_CNT_W 3

`endif

// ==== src/x86_decode_pkg.sv ====
`default_nettype none

`include "x86_decode_params.svh"

package x86_decode_pkg;

  // Operand encoding of the primary opcode
  typedef enum logic [3:0] {
    OPND_ENC_NONE,
    OPND_ENC_REG,
    OPND_ENC_IMM,
    OPND_ENC_REG_IMM,
    OPND_ENC_EAX_IMM,
    OPND_ENC_MODREGRM_RM,
    OPND_ENC_MODREGRM_REG_RM,
    OPND_ENC_MODREGRM_RM_REG,
    OPND_ENC_MODREGRM_RM_IMM,
    OPND_ENC_MODREGRM_REG_RM_IMM,
    OPND_ENC_MODREGRM_RM_REG_IMM,
    OPND_ENC_MODREGRM_RM_REG_CL,
    OPND_ENC_DISP8,
    OPND_ENC_DISP32,
    OPND_ENC_INVALID
  } opnd_form_t;

  // ModR/M, SIB or opcode byte
  typedef logic [`X86_BYTE_W-1:0] byte_t;
  // Displacement after sign extension
  typedef logic [`X86_DISP_W-1:0] disp_t;
  // Immediate, zero-extended from its little-endian bytes
  typedef logic [`X86_IMM_W-1:0] imm_t;
  // Total instruction length in bytes
  typedef logic [`X86_LEN_W-1:0] instr_len_t;
  typedef logic [`X86_OPC_BYTES*8-1:0] opc_window_t;
  typedef logic [`X86_WINDOW_BYTES*8-1:0] window_t;

  // Which operand takes each ModR/M field and the displacement
  typedef struct packed {
    logic opnd0_modrm_rm;
    logic opnd0_modrm_reg;
    logic opnd0_disp;
    logic opnd1_modrm_rm;
    logic opnd1_modrm_reg;
    logic opnd1_disp;
  } opnd_roles_t;

  // Stage 1 register contents
  typedef struct packed {
    opc_window_t                  opc_window;
    logic [`X86_PREFIX_CNT_W-1:0] prefix_count;
    logic                         prefix_operand_16bit;
    logic                         prefix_address_16bit;
    opnd_form_t                   opnd_form;
    logic                         imm_1byte;
    logic                         too_many_prefixes;
  } front_t;

  // Decoded instruction as presented at the output
  typedef struct packed {
    opnd_form_t  opnd_form;
    logic        invalid;
    logic        has_modrm;
    byte_t       modrm;
    logic        has_sib;
    byte_t       sib;
    logic        has_disp;
    logic        is_disp8;
    logic        is_disp32;
    disp_t       disp;
    logic        modrm_rm_is_reg_direct;
    opnd_roles_t roles;
    logic        has_imm;
    imm_t        imm;
    instr_len_t  length;
  } decode_result_t;

endpackage

`default_nettype wire

// ==== src/x86_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_decode_params.svh"

module x86_decode_top (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               in_valid,
  input  wire  x86_decode_pkg::window_t     in_bytes,
  output logic                              out_valid,
  output x86_decode_pkg::decode_result_t    out_result
);

  import x86_decode_pkg::*;

  // Stage 1 combinational results
  opc_window_t                  opc_window;
  logic [`X86_PREFIX_CNT_W-1:0] prefix_count;
  logic                         prefix_operand_16bit;
  logic                         prefix_address_16bit;
  logic                         too_many_prefixes;
  opnd_form_t                   opnd_form;
  logic                         imm_1byte;
  front_t                       front_d;

  // Stage 1 register
  front_t                       front_q;
  logic                         s1_valid;

  // Stage 2 combinational results
  logic                         has_imm;
  logic                         has_modrm;
  logic                         has_sib;
  logic                         has_disp;
  logic                         is_disp8;
  logic                         is_disp32;
  byte_t                        modrm;
  byte_t                        sib;
  disp_t                        disp;
  logic                         modrm_rm_is_reg_direct;
  opnd_roles_t                  roles;
  imm_t                         imm;
  instr_len_t                   calc_length;
  logic                         too_long;
  logic                         invalid;
  decode_result_t               result_d;

  prefix_strip prefix_strip_inst (
    .instr_bytes          (in_bytes),
    .opc_window           (opc_window),
    .prefix_count         (prefix_count),
    .prefix_operand_16bit (prefix_operand_16bit),
    .prefix_address_16bit (prefix_address_16bit),
    .too_many_prefixes    (too_many_prefixes)
  );

  // Primary opcode sits in byte 0 once prefixes are gone
  opcode_form_lookup opcode_form_lookup_inst (
    .opcode    (opc_window[7:0]),
    .opnd_form (opnd_form),
    .imm_1byte (imm_1byte)
  );

  assign front_d = '{
    opc_window:           opc_window,
    prefix_count:         prefix_count,
    prefix_operand_16bit: prefix_operand_16bit,
    prefix_address_16bit: prefix_address_16bit,
    opnd_form:            opnd_form,
    imm_1byte:            imm_1byte,
    too_many_prefixes:    too_many_prefixes
  };

  decode_opnd_signals decode_opnd_signals_inst (
    .unescaped_instr        (front_q.opc_window),
    .opnd_form              (front_q.opnd_form),
    .prefix_address_16bit   (front_q.prefix_address_16bit),
    .prefix_operand_16bit   (front_q.prefix_operand_16bit),
    .has_imm                (has_imm),
    .has_modrm              (has_modrm),
    .has_sib                (has_sib),
    .has_disp               (has_disp),
    .is_disp8               (is_disp8),
    .is_disp32              (is_disp32),
    .modrm                  (modrm),
    .sib                    (sib),
    .disp                   (disp),
    .modrm_rm_is_reg_direct (modrm_rm_is_reg_direct),
    .roles                  (roles)
  );

  instr_length_calc instr_length_calc_inst (
    .opc_window           (front_q.opc_window),
    .prefix_count         (front_q.prefix_count),
    .prefix_operand_16bit (front_q.prefix_operand_16bit),
    .has_modrm            (has_modrm),
    .has_sib              (has_sib),
    .has_disp             (has_disp),
    .is_disp8             (is_disp8),
    .has_imm              (has_imm),
    .imm_1byte            (front_q.imm_1byte),
    .imm                  (imm),
    .length               (calc_length),
    .too_long             (too_long)
  );

  // Unknown opcode, prefix overflow or over-length
  assign invalid = front_q.opnd_form == OPND_ENC_INVALID || front_q.too_many_prefixes
                   || too_long;

  always_comb begin
    result_d.opnd_form              = front_q.opnd_form;
    result_d.invalid                = invalid;
    result_d.has_modrm              = has_modrm;
    result_d.modrm                  = modrm;
    result_d.has_sib                = has_sib;
    result_d.sib                    = sib;
    result_d.has_disp               = has_disp;
    result_d.is_disp8               = is_disp8;
    result_d.is_disp32              = is_disp32;
    result_d.disp                   = disp;
    result_d.modrm_rm_is_reg_direct = modrm_rm_is_reg_direct;
    result_d.roles                  = roles;
    result_d.has_imm                = has_imm;
    result_d.imm                    = imm;
    // Invalid reports only the prefixes plus the offending byte
    result_d.length = invalid ? instr_len_t'(front_q.prefix_count) + instr_len_t'(1)
                              : calc_length;
  end

  // Strobes through both stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // Payload only loads alongside its strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      front_q <= front_d;
    end
    if (s1_valid) begin
      out_result <= result_d;
    end
  end

endmodule

`default_nettype wire
